//--- Bender.yml
package:
  name: slave_translator

sources:
  - rtl/slave_xlat_pkg.sv
  - rtl/access_timer.sv
  - rtl/read_latency_pipe.sv
  - rtl/slave_translator.sv
  - target: test
    files:
      - bench/timed_memory_model.sv
      - bench/slave_translator_tb.sv

//--- bench/slave_translator_tb.sv
// testbench for the avalon slave translator
// wait-state config first, then a zero-wait config with random back-to-back traffic
module slave_translator_tb;

   localparam int NCFG           = 2;
   localparam int DATA_W         = slave_xlat_pkg::DATA_W;
   localparam int BE_W           = DATA_W / 8;
   localparam int UAV_ADDR_W     = slave_xlat_pkg::UAV_ADDR_W;
   localparam int AV_ADDR_W      = slave_xlat_pkg::AV_ADDR_W;
   localparam int WORDS          = 16;                // word window used by the tests
   localparam int RANDOM_CMDS    = 200;
   localparam int TIMEOUT_CYCLES = RANDOM_CMDS * 10 + 200;

   logic                  clk;
   logic                  reset;
   logic [UAV_ADDR_W-1:0] uav_address        [NCFG];
   logic                  uav_read           [NCFG];
   logic                  uav_write          [NCFG];
   logic [DATA_W-1:0]     uav_writedata      [NCFG];
   logic [BE_W-1:0]       uav_byteenable     [NCFG];
   logic                  uav_waitrequest    [NCFG];
   logic                  uav_readdatavalid  [NCFG];
   logic [DATA_W-1:0]     uav_readdata       [NCFG];
   logic [AV_ADDR_W-1:0]  av_address         [NCFG];
   logic                  av_read            [NCFG];
   logic                  av_write           [NCFG];
   logic [DATA_W-1:0]     av_writedata       [NCFG];
   logic [BE_W-1:0]       av_byteenable      [NCFG];
   logic [BE_W-1:0]       av_writebyteenable [NCFG];
   logic                  av_chipselect      [NCFG];
   logic                  av_begintransfer   [NCFG];
   logic [DATA_W-1:0]     av_readdata        [NCFG];

   logic [DATA_W-1:0] shadow [NCFG][WORDS];   // reference memory contents
   logic [DATA_W-1:0] exp_data_q [$];
   int                exp_due_q [$];
   int                cyc;
   int                phase;                  // config under test
   int                errors;
   int                reads_issued;
   int                valids_seen;
   int                max_in_flight;

   // --------------------------------------------------
   // configurations
   // --------------------------------------------------
   function automatic int setup_of(input int c);
      return (c == 0) ? 1 : 0;
   endfunction

   function automatic int read_wait_of(input int c);
      return (c == 0) ? 2 : 0;
   endfunction

   function automatic int write_wait_of(input int c);
      return (c == 0) ? 1 : 0;
   endfunction

   function automatic int hold_of(input int c);
      return (c == 0) ? 1 : 0;
   endfunction

   function automatic int latency_of(input int c);
      return (c == 0) ? 2 : 3;
   endfunction

   generate
      for (genvar g = 0; g < NCFG; g++) begin : g_cfg
         slave_translator #(
            .DATA_W       (DATA_W),
            .UAV_ADDR_W   (UAV_ADDR_W),
            .AV_ADDR_W    (AV_ADDR_W),
            .SETUP_WAIT   (setup_of(g)),
            .READ_WAIT    (read_wait_of(g)),
            .WRITE_WAIT   (write_wait_of(g)),
            .HOLD_WAIT    (hold_of(g)),
            .READ_LATENCY (latency_of(g))
         ) u_slave_translator (
            .clk                (clk),
            .reset              (reset),
            .uav_address        (uav_address[g]),
            .uav_read           (uav_read[g]),
            .uav_write          (uav_write[g]),
            .uav_writedata      (uav_writedata[g]),
            .uav_byteenable     (uav_byteenable[g]),
            .uav_waitrequest    (uav_waitrequest[g]),
            .uav_readdatavalid  (uav_readdatavalid[g]),
            .uav_readdata       (uav_readdata[g]),
            .av_address         (av_address[g]),
            .av_read            (av_read[g]),
            .av_write           (av_write[g]),
            .av_writedata       (av_writedata[g]),
            .av_byteenable      (av_byteenable[g]),
            .av_writebyteenable (av_writebyteenable[g]),
            .av_chipselect      (av_chipselect[g]),
            .av_begintransfer   (av_begintransfer[g]),
            .av_readdata        (av_readdata[g])
         );

         timed_memory_model #(
            .DATA_W       (DATA_W),
            .ADDR_W       (AV_ADDR_W),
            .READ_LATENCY (latency_of(g))
         ) u_memory (
            .clk                (clk),
            .av_address         (av_address[g]),
            .av_write           (av_write[g]),
            .av_writebyteenable (av_writebyteenable[g]),
            .av_writedata       (av_writedata[g]),
            .av_readdata        (av_readdata[g])
         );
      end
   endgenerate

   // --------------------------------------------------
   // reference and reporting
   // --------------------------------------------------

   // merges a write at acceptance, returns the current word
   function automatic logic [DATA_W-1:0] mem_ref(input int c, input bit do_write,
                                                 input int word, input logic [BE_W-1:0] be,
                                                 input logic [DATA_W-1:0] data);
      if (do_write) begin
         for (int b = 0; b < BE_W; b++) begin
            if (be[b]) begin
               shadow[c][word][8*b +: 8] = data[8*b +: 8];
            end
         end
      end
      return shadow[c][word];
   endfunction

   task automatic fail_now(input string msg);
      $display("%s", msg);
      $display("*** TEST FAILED ***");
      errors++;
      $fatal(1, "stopping at first error");
   endtask

   task automatic check_equal(input string name, input logic [DATA_W-1:0] expected,
                              input logic [DATA_W-1:0] actual);
      assert (actual === expected)
      else fail_now($sformatf("error: %s expected %0h actual %0h", name, expected, actual));
   endtask

   // --------------------------------------------------
   // clock, cycle count and timeout
   // --------------------------------------------------
   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   initial begin
      cyc = 0;
      max_in_flight = 0;
      forever begin
         @(negedge clk);
         cyc++;
         if (exp_data_q.size() > max_in_flight) begin
            max_in_flight = exp_data_q.size();
         end
         if (cyc > TIMEOUT_CYCLES) begin
            fail_now("timeout, the run did not finish within the cycle limit");
         end
      end
   end

   // --------------------------------------------------
   // checker for read data, chipselect and idle lanes
   // --------------------------------------------------
   initial begin
      logic [DATA_W-1:0] expected;
      int                due;
      forever begin
         @(posedge clk);
         if (!reset) begin
            for (int c = 0; c < NCFG; c++) begin
               if (c != phase) begin
                  check_equal("idle valid", 1'b0, uav_readdatavalid[c]);
                  check_equal("idle chipselect", 1'b0, av_chipselect[c]);
               end else begin
                  check_equal("chipselect", uav_read[c] | uav_write[c] |
                              (exp_data_q.size() > 0), av_chipselect[c]);
                  if (!uav_write[c]) begin
                     check_equal("writebyteenable idle", '0, av_writebyteenable[c]);
                  end
                  if (uav_readdatavalid[c]) begin
                     assert (exp_data_q.size() > 0)
                     else fail_now("readdatavalid arrived with no read outstanding");
                     expected = exp_data_q.pop_front();
                     due = exp_due_q.pop_front();
                     valids_seen++;
                     check_equal("read latency", due, cyc);
                     check_equal("read data", expected, uav_readdata[c]);
                  end
               end
            end
         end
      end
   end

   // --------------------------------------------------
   // stimulus
   // --------------------------------------------------

   // one command, checked cycle by cycle until accepted
   task automatic run_cmd(input int c, input bit is_write, input logic [UAV_ADDR_W-1:0] addr,
                          input logic [BE_W-1:0] be, input logic [DATA_W-1:0] data,
                          input string name);
      int  k;
      int  done;
      int  word;
      bit  finished;
      logic [DATA_W-1:0] expected;
      @(negedge clk);
      uav_address[c]    = addr;
      uav_read[c]       = !is_write;
      uav_write[c]      = is_write;
      uav_writedata[c]  = data;
      uav_byteenable[c] = be;
      word = int'(addr >> 2);
      if (is_write) begin
         done = setup_of(c) + write_wait_of(c) + hold_of(c);
      end else begin
         done = setup_of(c) + read_wait_of(c);
      end
      k = 0;
      finished = 1'b0;
      while (!finished) begin
         @(posedge clk);
         check_equal({name, " waitrequest"}, k != done, uav_waitrequest[c]);
         check_equal({name, " begintransfer"}, k == 0, av_begintransfer[c]);
         check_equal({name, " address"}, addr >> 2, av_address[c]);
         check_equal({name, " byteenable"}, be, av_byteenable[c]);
         check_equal({name, " writebyteenable"}, is_write ? be : '0, av_writebyteenable[c]);
         if (is_write) begin
            check_equal({name, " av_write"},
                        (k >= setup_of(c)) && (k <= setup_of(c) + write_wait_of(c)),
                        av_write[c]);
            check_equal({name, " av_read"}, 1'b0, av_read[c]);
         end else begin
            check_equal({name, " av_read"}, k >= setup_of(c), av_read[c]);
            check_equal({name, " av_write"}, 1'b0, av_write[c]);
         end
         if (k == done) begin
            expected = mem_ref(c, is_write, word, be, data);
            if (!is_write) begin
               exp_data_q.push_back(expected);
               exp_due_q.push_back(cyc + latency_of(c));
               reads_issued++;
            end
            finished = 1'b1;
         end
         k++;
      end
   endtask

   task automatic go_idle(input int c);
      @(negedge clk);
      uav_read[c]  = 1'b0;
      uav_write[c] = 1'b0;
   endtask

   // every accepted read is due back within the fixed read latency
   task automatic drain_reads(input int c);
      repeat (latency_of(c) + 3) @(posedge clk);
   endtask

   initial begin
      logic [UAV_ADDR_W-1:0] addr;
      bit                    is_write;
      void'($urandom(32'hb89ceb3f));
      errors = 0;
      phase = 0;
      reads_issued = 0;
      valids_seen = 0;
      for (int c = 0; c < NCFG; c++) begin
         uav_address[c]    = '0;
         uav_read[c]       = 1'b0;
         uav_write[c]      = 1'b0;
         uav_writedata[c]  = '0;
         uav_byteenable[c] = '0;
         for (int w = 0; w < WORDS; w++) begin
            shadow[c][w] = (w * 32'h9e3779b1) ^ 32'h5ac30f96;
         end
      end
      reset = 1'b1;
      repeat (16) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      // first cycle out of reset
      @(posedge clk);
      for (int c = 0; c < NCFG; c++) begin
         check_equal("reset waitrequest", 1'b1, uav_waitrequest[c]);
         check_equal("reset readdatavalid", 1'b0, uav_readdatavalid[c]);
         check_equal("reset av_read", 1'b0, av_read[c]);
         check_equal("reset av_write", 1'b0, av_write[c]);
         check_equal("reset chipselect", 1'b0, av_chipselect[c]);
         check_equal("reset begintransfer", 1'b0, av_begintransfer[c]);
      end
      repeat (2) @(posedge clk);

      // wait-state config, directed writes then reads
      run_cmd(0, 1'b1, 16'h0000, 4'hf, 32'h11223344, "write w0");
      run_cmd(0, 1'b1, 16'h0004, 4'h1, 32'haabbccdd, "write w1");
      run_cmd(0, 1'b1, 16'h0009, 4'h6, 32'h01020304, "write w2");
      run_cmd(0, 1'b1, 16'h000e, 4'h8, 32'hdeadbeef, "write w3");
      go_idle(0);
      run_cmd(0, 1'b1, 16'h0010, 4'hc, 32'hcafef00d, "write w4");
      for (int w = 0; w < 7; w++) begin
         run_cmd(0, 1'b0, (w << 2) | (w & 3), 4'hf, '0, $sformatf("read w%0d", w));
      end
      run_cmd(0, 1'b1, 16'h0018, 4'h3, 32'h5555aaaa, "write w6");
      run_cmd(0, 1'b0, 16'h001b, 4'hf, '0, "read back w6");
      go_idle(0);
      drain_reads(0);

      // zero-wait config, random back-to-back traffic
      phase = 1;
      max_in_flight = 0;
      for (int n = 0; n < RANDOM_CMDS; n++) begin
         is_write = $urandom_range(0, 1);
         addr = ($urandom_range(0, WORDS - 1) << 2) | $urandom_range(0, 3);
         run_cmd(1, is_write, addr, $urandom_range(1, 15), $urandom,
                 $sformatf("random %0d", n));
      end
      go_idle(1);
      drain_reads(1);
      check_equal("readdatavalid count", reads_issued, valids_seen);
      check_equal("reads in flight", latency_of(1), max_in_flight);

      if (errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

//--- bench/timed_memory_model.sv
// fixed-timing memory slave for the translator testbench
// no waitrequest, read data appears a fixed number of cycles after the read
module timed_memory_model #(
   parameter int DATA_W       = 32,
   parameter int ADDR_W       = 14,
   parameter int READ_LATENCY = 1
) (
   input  logic                clk,
   input  logic [ADDR_W-1:0]   av_address,
   input  logic                av_write,
   input  logic [DATA_W/8-1:0] av_writebyteenable,
   input  logic [DATA_W-1:0]   av_writedata,
   output logic [DATA_W-1:0]   av_readdata
);

   localparam int DEPTH = 1 << ADDR_W;

   logic [DATA_W-1:0] mem [DEPTH];
   logic [DATA_W-1:0] data_pipe [READ_LATENCY];   // read data on its way out

   // every word starts from a pattern of its whole address
   initial begin
      for (int i = 0; i < DEPTH; i++) begin
         mem[i] = (i * 32'h9e3779b1) ^ 32'h5ac30f96;
      end
   end

   always @(posedge clk) begin
      data_pipe[0] <= mem[av_address];    // word before this cycle's write
      for (int i = 1; i < READ_LATENCY; i++) begin
         data_pipe[i] <= data_pipe[i-1];
      end
      if (av_write) begin
         for (int b = 0; b < DATA_W / 8; b++) begin
            if (av_writebyteenable[b]) begin
               mem[av_address][8*b +: 8] <= av_writedata[8*b +: 8];
            end
         end
      end
   end

   assign av_readdata = data_pipe[READ_LATENCY-1];

endmodule

//--- rtl/access_timer.sv
// wait-state timer for a fixed-timing avalon slave
// shapes read/write strobes, waitrequest and begintransfer
module access_timer #(
   parameter int SETUP_WAIT = slave_xlat_pkg::DEF_SETUP_WAIT,
   parameter int READ_WAIT  = slave_xlat_pkg::DEF_READ_WAIT,
   parameter int WRITE_WAIT = slave_xlat_pkg::DEF_WRITE_WAIT,
   parameter int HOLD_WAIT  = slave_xlat_pkg::DEF_HOLD_WAIT
) (
   input  logic clk,
   input  logic reset,

   // upstream command
   input  logic uav_read,
   input  logic uav_write,
   output logic uav_waitrequest,

   // downstream strobes
   output logic av_read,
   output logic av_write,
   output logic av_begintransfer,

   // to the read latency pipe
   output logic read_accept
);

   // count values at which each phase ends
   localparam int READ_DONE  = SETUP_WAIT + READ_WAIT;    // read accepted here
   localparam int WRITE_END  = SETUP_WAIT + WRITE_WAIT;   // last av_write cycle
   localparam int WRITE_DONE = WRITE_END + HOLD_WAIT;     // write accepted here

   localparam int CNT_W = slave_xlat_pkg::wait_count_w(READ_DONE, WRITE_DONE);

   logic [CNT_W-1:0] wait_count;       // cycles spent on current command
   logic             reset_override;   // forces waitrequest right after reset
   logic             end_begintransfer;
   logic             command;
   logic             wait_read;
   logic             wait_write;

   assign command = uav_read | uav_write;

   // --------------------------------------------------
   // wait counter
   // --------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         wait_count     <= '0;
         reset_override <= 1'b1;
      end else begin
         reset_override <= 1'b0;
         if (!uav_waitrequest || reset_override) begin
            wait_count <= '0;                   // command accepted, start over
         end else if (command) begin
            wait_count <= wait_count + 1'b1;
         end else begin
            wait_count <= '0;
         end
      end
   end

   // --------------------------------------------------
   // strobes and waitrequest
   // --------------------------------------------------
   always_comb begin
      wait_read  = (wait_count != READ_DONE);
      wait_write = (wait_count != WRITE_DONE);

      // strobes open after setup, write closes before the hold phase
      av_read  = uav_read && (wait_count >= SETUP_WAIT);
      av_write = uav_write && (wait_count >= SETUP_WAIT) && (wait_count <= WRITE_END);

      // idle falls back to the read threshold
      if (uav_write) begin
         uav_waitrequest = wait_write | reset_override;
      end else begin
         uav_waitrequest = wait_read | reset_override;
      end
   end

   assign read_accept = uav_read & ~uav_waitrequest;

   // --------------------------------------------------
   // begintransfer
   // --------------------------------------------------

   // one pulse per command, suppressed while it waits
   assign av_begintransfer = command & ~end_begintransfer;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         end_begintransfer <= 1'b0;
      end else begin
         if (av_begintransfer && uav_waitrequest && !reset_override) begin
            end_begintransfer <= 1'b1;     // first cycle seen, still stalled
         end else if (!uav_waitrequest) begin
            end_begintransfer <= 1'b0;     // accepted, rearm for next command
         end
      end
   end

   // --------------------------------------------------
   // upstream protocol checks
   // --------------------------------------------------

   // master keeps its command until waitrequest drops
   cmd_held_under_wait: assert property (
      @(posedge clk) disable iff (reset)
      command && uav_waitrequest |=> $stable(uav_read) && $stable(uav_write)
   ) else $error("access_timer: command changed while waitrequest was high");

   // never read and write together
   single_command: assert property (
      @(posedge clk) disable iff (reset)
      !(uav_read && uav_write)
   ) else $error("access_timer: read and write asserted together");

endmodule

//--- rtl/read_latency_pipe.sv
// fixed read latency tracker
// delays each accepted read to readdatavalid, flags reads in flight
module read_latency_pipe #(
   parameter int READ_LATENCY = slave_xlat_pkg::DEF_READ_LATENCY
) (
   input  logic clk,
   input  logic reset,

   input  logic read_accept,          // read accepted this cycle
   output logic uav_readdatavalid,    // data from the slave is valid
   output logic cs_extend             // reads still ahead of the output
);

   // stage[i] marks a read accepted i+1 cycles ago
   logic [READ_LATENCY-1:0] stage;

   // --------------------------------------------------
   // parameter check
   // --------------------------------------------------
   generate
      if (READ_LATENCY < 1) begin : g_latency_check
         $fatal(1, "read_latency_pipe: READ_LATENCY must be at least 1");
      end
   endgenerate

   // --------------------------------------------------
   // shift register
   // --------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         stage <= '0;
      end else begin
         stage[0] <= read_accept;
         for (int i = 1; i < READ_LATENCY; i++) begin
            stage[i] <= stage[i-1];
         end
      end
   end

   // last stage lines up with slave readdata
   assign uav_readdatavalid = stage[READ_LATENCY-1];

   // --------------------------------------------------
   // chipselect extension
   // --------------------------------------------------

   // any read not yet at the output keeps the slave selected,
   // the emerging one is covered by the registered chipselect
   generate
      if (READ_LATENCY > 1) begin : g_extend
         assign cs_extend = |stage[READ_LATENCY-2:0];
      end else begin : g_no_extend
         assign cs_extend = 1'b0;    // single stage is always the emerging one
      end
   endgenerate

endmodule

//--- rtl/slave_translator.sv
// avalon slave translator top
// byte-addressed avalon slave port to a fixed-timing word-addressed slave
module slave_translator #(
   parameter int DATA_W       = slave_xlat_pkg::DATA_W,
   parameter int UAV_ADDR_W   = slave_xlat_pkg::UAV_ADDR_W,
   parameter int AV_ADDR_W    = slave_xlat_pkg::AV_ADDR_W,
   parameter int SETUP_WAIT   = slave_xlat_pkg::DEF_SETUP_WAIT,
   parameter int READ_WAIT    = slave_xlat_pkg::DEF_READ_WAIT,
   parameter int WRITE_WAIT   = slave_xlat_pkg::DEF_WRITE_WAIT,
   parameter int HOLD_WAIT    = slave_xlat_pkg::DEF_HOLD_WAIT,
   parameter int READ_LATENCY = slave_xlat_pkg::DEF_READ_LATENCY
) (
   input  logic                    clk,
   input  logic                    reset,

   // --------------------------------------------------
   // upstream avalon slave port
   // --------------------------------------------------
   input  logic [UAV_ADDR_W-1:0]   uav_address,
   input  logic                    uav_read,
   input  logic                    uav_write,
   input  logic [DATA_W-1:0]       uav_writedata,
   input  logic [DATA_W/8-1:0]     uav_byteenable,
   output logic                    uav_waitrequest,
   output logic                    uav_readdatavalid,
   output logic [DATA_W-1:0]       uav_readdata,

   // --------------------------------------------------
   // downstream fixed-timing slave
   // --------------------------------------------------
   output logic [AV_ADDR_W-1:0]    av_address,
   output logic                    av_read,
   output logic                    av_write,
   output logic [DATA_W-1:0]       av_writedata,
   output logic [DATA_W/8-1:0]     av_byteenable,
   output logic [DATA_W/8-1:0]     av_writebyteenable,
   output logic                    av_chipselect,
   output logic                    av_begintransfer,
   input  logic [DATA_W-1:0]       av_readdata
);

   localparam int BE_W  = DATA_W / 8;
   localparam int OFS_W = $clog2(BE_W);   // byte offset bits in uav_address

   logic read_accept;
   logic cs_extend;
   logic cs_hold;      // chipselect carried past the command

   generate
      if (UAV_ADDR_W < AV_ADDR_W + OFS_W) begin : g_addr_check
         $fatal(1, "slave_translator: upstream address too narrow for AV_ADDR_W");
      end
   endgenerate

   // --------------------------------------------------
   // address, data and byte lanes
   // --------------------------------------------------
   assign av_address    = uav_address[OFS_W +: AV_ADDR_W];   // byte to word
   assign av_writedata  = uav_writedata;
   assign av_byteenable = uav_byteenable;

   // lanes only qualified during a write
   assign av_writebyteenable = {BE_W{uav_write}} & uav_byteenable;

   assign uav_readdata = av_readdata;      // slave data lines up with valid

   // --------------------------------------------------
   // timing control
   // --------------------------------------------------
   access_timer #(
      .SETUP_WAIT (SETUP_WAIT),
      .READ_WAIT  (READ_WAIT),
      .WRITE_WAIT (WRITE_WAIT),
      .HOLD_WAIT  (HOLD_WAIT)
   ) u_access_timer (
      .clk              (clk),
      .reset            (reset),
      .uav_read         (uav_read),
      .uav_write        (uav_write),
      .uav_waitrequest  (uav_waitrequest),
      .av_read          (av_read),
      .av_write         (av_write),
      .av_begintransfer (av_begintransfer),
      .read_accept      (read_accept)
   );

   read_latency_pipe #(
      .READ_LATENCY (READ_LATENCY)
   ) u_read_latency_pipe (
      .clk               (clk),
      .reset             (reset),
      .read_accept       (read_accept),
      .uav_readdatavalid (uav_readdatavalid),
      .cs_extend         (cs_extend)
   );

   // --------------------------------------------------
   // chipselect
   // --------------------------------------------------

   // one cycle behind the read or pending stages, so it
   // covers the emerging read and drops right after it
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         cs_hold <= 1'b0;
      end else begin
         cs_hold <= uav_read | cs_extend;
      end
   end

   assign av_chipselect = uav_read | uav_write | cs_hold;

endmodule

//--- rtl/slave_xlat_pkg.sv
// shared defaults for the avalon slave translator
// bus widths, fixed slave timing and wait counter sizing
package slave_xlat_pkg;

   // --------------------------------------------------
   // bus widths
   // --------------------------------------------------
   localparam int DATA_W         = 32;
   localparam int BYTES_PER_WORD = DATA_W / 8;      // byte lanes on the data bus
   localparam int UAV_ADDR_W     = 16;              // upstream byte address

   // word address loses the byte offset bits
   localparam int AV_ADDR_W = UAV_ADDR_W - $clog2(BYTES_PER_WORD);

   // --------------------------------------------------
   // fixed timing of the downstream slave
   // --------------------------------------------------
   localparam int DEF_SETUP_WAIT   = 0;   // cycles before read/write strobe
   localparam int DEF_READ_WAIT    = 0;   // extra cycles of a read strobe
   localparam int DEF_WRITE_WAIT   = 0;   // extra cycles of a write strobe
   localparam int DEF_HOLD_WAIT    = 0;   // data held after write strobe
   localparam int DEF_READ_LATENCY = 1;   // acceptance to readdata

   // --------------------------------------------------
   // helpers
   // --------------------------------------------------

   // width of a counter reaching the larger of the two totals
   // never less than one bit, even when both totals are zero
   function automatic int wait_count_w(input int read_total, input int write_total);
      int top;
      top = (read_total > write_total) ? read_total : write_total;
      if (top > 0) begin
         return $clog2(top + 1);
      end
      return 1;
   endfunction

endpackage

//--- sim.f
rtl/slave_xlat_pkg.sv
rtl/access_timer.sv
rtl/read_latency_pipe.sv
rtl/slave_translator.sv
bench/timed_memory_model.sv
bench/slave_translator_tb.sv
